// File: include/pers_macros.svh
`ifndef PERS_MACROS_SVH
`define PERS_MACROS_SVH

// **************************************************************************
// Dispatch widths
// **************************************************************************

`define PERS_INST_W       32
`define PERS_DATA_W       64
`define PERS_AEG_IDX_W    18

// Number of implemented AEGs
`define PERS_AEG_CNT      2

// **************************************************************************
// Launch timing
// **************************************************************************

// Busy cycles held after a command goes out
`define PERS_MIN_BUSY     32

// Busy cycles before the chain is forced idle
`define PERS_WDOG_LIMIT   512

// Idle command, opcode in bits 2..0 and argument in bits 7..3
`define PERS_IDLE_OPC     3'd1
`define PERS_IDLE_ARG     5'd16

`endif

// File: rtl/pers_pkg.sv
`include "pers_macros.svh"

package pers_pkg;

   // Raw words
   typedef logic [`PERS_INST_W-1:0]    inst_t;
   typedef logic [`PERS_DATA_W-1:0]    data_t;
   typedef logic [`PERS_AEG_IDX_W-1:0] aeg_idx_t;

   // Major opcode, instruction bits 31..29
   typedef enum logic [2:0] {
      OP_AEG_WR = 3'd1,
      OP_AEG_RD = 3'd2,
      OP_CAEP   = 3'd4
   } pers_op_e;

   // Custom instruction number, bits 28..24
   typedef enum logic [4:0] {
      CAEP_NOP    = 5'd0,
      CAEP_LAUNCH = 5'd1,
      CAEP_NOP2   = 5'd2
   } caep_e;

   // **********************************************************************
   // Launch sequencing
   // **********************************************************************

   typedef enum logic [1:0] {
      LAUNCH_IDLE,
      LAUNCH_SEND,
      LAUNCH_HOLD
   } launch_state_e;

endpackage

// File: rtl/dispatch_if.sv
interface dispatch_if
   import pers_pkg::*;
();

   logic     val;
   caep_e    caep;
   logic     aeg_wr;
   logic     aeg_rd;
   aeg_idx_t aeg_idx;
   data_t    data;
   logic     err_unimpl;

   modport dec (
      output val, caep, aeg_wr, aeg_rd, aeg_idx, data, err_unimpl
   );

   // Register bank side
   modport aeg (
      input aeg_wr, aeg_rd, aeg_idx, data
   );

   modport launch (
      input val, caep, err_unimpl
   );

endinterface

// File: rtl/inst_decode.sv
module inst_decode
   import pers_pkg::*;
(
   input  inst_t      inst_i,
   input  data_t      data_i,
   input  logic       inst_vld_i,
   dispatch_if.dec    disp
);

   pers_op_e op;
   caep_e    caep_fld;
   logic     op_known;
   logic     caep_known;

   assign op       = pers_op_e'(inst_i[31:29]);
   assign caep_fld = caep_e'(inst_i[28:24]);

   always_comb begin
      case (op)
         OP_AEG_WR,
         OP_AEG_RD,
         OP_CAEP:   op_known = 1'b1;
         default:   op_known = 1'b0;
      endcase
   end

   always_comb begin
      case (caep_fld)
         CAEP_NOP,
         CAEP_LAUNCH,
         CAEP_NOP2: caep_known = 1'b1;
         default:   caep_known = 1'b0;
      endcase
   end

   // **********************************************************************
   // Decoded dispatch
   // **********************************************************************

   assign disp.val     = inst_vld_i;
   assign disp.aeg_wr  = inst_vld_i && (op == OP_AEG_WR);
   assign disp.aeg_rd  = inst_vld_i && (op == OP_AEG_RD);
   assign disp.aeg_idx = inst_i[17:0];
   assign disp.data    = data_i;

   // CAEP field only means something for a CAEP opcode
   assign disp.caep = (op == OP_CAEP) ? caep_fld : CAEP_NOP;

   assign disp.err_unimpl = inst_vld_i &&
                            (!op_known || ((op == OP_CAEP) && !caep_known));

endmodule

// File: rtl/aeg_regs.sv
`include "pers_macros.svh"

module aeg_regs
   import pers_pkg::*;
(
   input  logic       clk,
   input  logic       reset_per,
   dispatch_if.aeg    disp,
   output data_t      ret_data_o,
   output logic       ret_data_vld_o,
   output logic       err_aegidx_o,
   output data_t      aeg0_o
);

   localparam int SEL_W = $clog2(`PERS_AEG_CNT);

   data_t             aeg_q [`PERS_AEG_CNT];
   data_t             ret_data_q;
   logic              ret_vld_q;
   logic              err_idx_q;
   logic              idx_ok;
   logic [SEL_W-1:0]  sel;

   // Low index bits pick the register once the range check passes
   assign idx_ok = disp.aeg_idx < aeg_idx_t'(`PERS_AEG_CNT);
   assign sel    = disp.aeg_idx[SEL_W-1:0];

   // **********************************************************************
   // Register bank
   // **********************************************************************

   always_ff @(posedge clk) begin
      if (reset_per) begin
         for (int i = 0; i < `PERS_AEG_CNT; i++) begin
            aeg_q[i] <= '0;
         end
      end else begin
         for (int i = 0; i < `PERS_AEG_CNT; i++) begin
            if (disp.aeg_wr && idx_ok && (sel == SEL_W'(i))) begin
               aeg_q[i] <= disp.data;
            end
         end
      end
   end

   // Read return, one cycle after the dispatch
   always_ff @(posedge clk) begin
      if (disp.aeg_rd && idx_ok) begin
         ret_data_q <= aeg_q[sel];
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         ret_vld_q <= 1'b0;
         err_idx_q <= 1'b0;
      end else begin
         ret_vld_q <= disp.aeg_rd && idx_ok;
         err_idx_q <= (disp.aeg_wr || disp.aeg_rd) && !idx_ok;
      end
   end

   assign ret_data_o     = ret_data_q;
   assign ret_data_vld_o = ret_vld_q;
   assign err_aegidx_o   = err_idx_q;

   // AEG 0 holds the command word for a launch
   assign aeg0_o = aeg_q[0];

endmodule

// File: rtl/launch_ctl.sv
`include "pers_macros.svh"

module launch_ctl
   import pers_pkg::*;
(
   input  logic       clk,
   input  logic       reset_per,
   dispatch_if.launch disp,
   input  data_t      aeg0_i,
   input  logic       pe_busy_i,
   output logic       err_unimpl_o,
   output data_t      pe_cmd_o,
   output logic       busy_o
);

   localparam int HOLD_W = $clog2(`PERS_MIN_BUSY);
   localparam int WDOG_W = $clog2(`PERS_WDOG_LIMIT);

   localparam data_t IDLE_CMD = data_t'({`PERS_IDLE_ARG, `PERS_IDLE_OPC});

   launch_state_e     state_q;
   logic [HOLD_W-1:0] hold_cnt_q;
   logic [WDOG_W-1:0] wdog_cnt_q;
   data_t             pe_cmd_q;
   logic              err_unimpl_q;
   logic              launch_req;
   logic              send_stb;
   logic              busy;
   logic              wdog_expire;

   assign launch_req = disp.val && (disp.caep == CAEP_LAUNCH);
   assign send_stb   = (state_q == LAUNCH_SEND);

   // Busy from the dispatch cycle onward, plus the external chain
   assign busy = launch_req || (state_q != LAUNCH_IDLE) || pe_busy_i;

   assign wdog_expire = busy && (wdog_cnt_q == WDOG_W'(`PERS_WDOG_LIMIT - 1));

   // **********************************************************************
   // Launch FSM and minimum busy window
   // **********************************************************************

   always_ff @(posedge clk) begin
      if (reset_per) begin
         state_q    <= LAUNCH_HOLD;
         hold_cnt_q <= '0;
      end else begin
         case (state_q)
            LAUNCH_IDLE: begin
               if (launch_req) begin
                  state_q <= LAUNCH_SEND;
               end
            end
            LAUNCH_SEND: begin
               state_q    <= LAUNCH_HOLD;
               hold_cnt_q <= '0;
            end
            LAUNCH_HOLD: begin
               hold_cnt_q <= hold_cnt_q + 1'b1;
               if (hold_cnt_q == HOLD_W'(`PERS_MIN_BUSY - 1)) begin
                  state_q <= LAUNCH_IDLE;
               end
            end
            default: state_q <= LAUNCH_IDLE;
         endcase
      end
   end

   // Watchdog counts busy cycles only
   always_ff @(posedge clk) begin
      if (reset_per || !busy || wdog_expire) begin
         wdog_cnt_q <= '0;
      end else begin
         wdog_cnt_q <= wdog_cnt_q + 1'b1;
      end
   end

   // Command word, idle command wins over a send
   always_ff @(posedge clk) begin
      if (reset_per || wdog_expire) begin
         pe_cmd_q <= IDLE_CMD;
      end else if (send_stb) begin
         pe_cmd_q <= aeg0_i;
      end else begin
         pe_cmd_q <= '0;
      end
   end

   always_ff @(posedge clk) begin
      if (reset_per) begin
         err_unimpl_q <= 1'b0;
      end else begin
         err_unimpl_q <= disp.err_unimpl;
      end
   end

   assign err_unimpl_o = err_unimpl_q;
   assign pe_cmd_o     = pe_cmd_q;
   assign busy_o       = busy;

endmodule

// File: rtl/pers_top.sv
`include "pers_macros.svh"

module pers_top
   import pers_pkg::*;
(
   input  logic     clk,
   input  logic     reset_per,

   // Host dispatch
   input  inst_t    inst_i,
   input  data_t    data_i,
   input  logic     inst_vld_i,

   output aeg_idx_t aeg_cnt_o,
   output logic [15:0] exception_o,
   output data_t    ret_data_o,
   output logic     ret_data_vld_o,
   output logic     idle_o,
   output logic     stall_o,

   // External PE chain
   output data_t    pe_cmd_o,
   input  logic     pe_busy_i
);

   data_t aeg0;
   logic  err_unimpl;
   logic  err_aegidx;
   logic  busy;

   dispatch_if disp_if ();

   // **********************************************************************
   // Decode and consumers
   // **********************************************************************

   inst_decode u_decode (
      .inst_i     (inst_i),
      .data_i     (data_i),
      .inst_vld_i (inst_vld_i),
      .disp       (disp_if)
   );

   aeg_regs u_aeg (
      .clk            (clk),
      .reset_per      (reset_per),
      .disp           (disp_if),
      .ret_data_o     (ret_data_o),
      .ret_data_vld_o (ret_data_vld_o),
      .err_aegidx_o   (err_aegidx),
      .aeg0_o         (aeg0)
   );

   launch_ctl u_launch (
      .clk          (clk),
      .reset_per    (reset_per),
      .disp         (disp_if),
      .aeg0_i       (aeg0),
      .pe_busy_i    (pe_busy_i),
      .err_unimpl_o (err_unimpl),
      .pe_cmd_o     (pe_cmd_o),
      .busy_o       (busy)
   );

   // **********************************************************************
   // Status back to the host
   // **********************************************************************

   assign aeg_cnt_o = aeg_idx_t'(`PERS_AEG_CNT);

   // Bit 0 unimplemented, bit 1 AEG index
   assign exception_o = {14'b0, err_aegidx, err_unimpl};

   assign stall_o = busy;
   assign idle_o  = !busy;

endmodule

// File: bench/pers_tb.sv
`include "pers_macros.svh"

module pers_tb
   import pers_pkg::*;
();

   localparam int RESET_CYCLES   = 5;
   localparam int BUSY_HOLD      = 600;
   // Longest test is the busy hold plus a few hundred cycles for the rest
   localparam int TIMEOUT_CYCLES = 4000;

   logic        clk;
   logic        reset_per;
   inst_t       inst_i;
   data_t       data_i;
   logic        inst_vld_i;
   logic        pe_busy_i;
   aeg_idx_t    aeg_cnt_o;
   logic [15:0] exception_o;
   data_t       ret_data_o;
   logic        ret_data_vld_o;
   logic        idle_o;
   logic        stall_o;
   data_t       pe_cmd_o;

   int          errors;
   int          checks;
   integer      seed;
   logic        stall_at_disp;
   data_t       aeg_model [2];
   data_t       idle_cmd;

   pers_top uut (
      .clk            (clk),
      .reset_per      (reset_per),
      .inst_i         (inst_i),
      .data_i         (data_i),
      .inst_vld_i     (inst_vld_i),
      .pe_busy_i      (pe_busy_i),
      .aeg_cnt_o      (aeg_cnt_o),
      .exception_o    (exception_o),
      .ret_data_o     (ret_data_o),
      .ret_data_vld_o (ret_data_vld_o),
      .idle_o         (idle_o),
      .stall_o        (stall_o),
      .pe_cmd_o       (pe_cmd_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   initial begin
      repeat (TIMEOUT_CYCLES) @(posedge clk);
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $finish;
   end

   // **********************************************************************
   // Compare tasks
   // **********************************************************************

   task check_data(input data_t got, input data_t exp, input string name);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
      end
   endtask

   task check_bit(input logic got, input logic exp, input string name);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
      end
   endtask

   task check_exc(input logic [15:0] got, input logic [15:0] exp);
      checks++;
      if (got !== exp) begin
         errors++;
         $display("Mismatch at %0t: exception_o is %h, expected %h", $time, got, exp);
      end
   endtask

   task check_count(input int got, input int exp, input string name);
      checks++;
      if (got != exp) begin
         errors++;
         $display("Mismatch at %0t: %s is %0d, expected %0d", $time, name, got, exp);
      end
   endtask

   // **********************************************************************
   // Stimulus helpers
   // **********************************************************************

   // Opcode 31..29, CAEP 28..24, index 17..0
   function automatic inst_t make_inst(input logic [2:0] op, input logic [4:0] caep,
                                       input aeg_idx_t idx);
      make_inst = {op, caep, 6'b0, idx};
   endfunction

   function data_t rand_data();
      rand_data = {$random(seed), $random(seed)};
   endfunction

   function automatic data_t expected_idle_cmd();
      data_t cmd;
      cmd      = '0;
      cmd[2:0] = `PERS_IDLE_OPC;
      cmd[7:3] = `PERS_IDLE_ARG;
      expected_idle_cmd = cmd;
   endfunction

   task next_cycle();
      @(negedge clk);
      #1;
   endtask

   // One-cycle strobe that returns in the cycle after the dispatch
   task dispatch(input inst_t inst, input data_t data);
      @(negedge clk);
      inst_i     = inst;
      data_i     = data;
      inst_vld_i = 1'b1;
      #1;
      stall_at_disp = stall_o;
      @(negedge clk);
      inst_i     = '0;
      data_i     = '0;
      inst_vld_i = 1'b0;
      #1;
   endtask

   task read_and_check(input int idx);
      dispatch(make_inst(OP_AEG_RD, 5'd0, aeg_idx_t'(idx)), '0);
      check_bit(ret_data_vld_o, 1'b1, "ret_data_vld_o");
      check_data(ret_data_o, aeg_model[idx], "ret_data_o");
      check_exc(exception_o, 16'h0000);
      next_cycle();
      check_bit(ret_data_vld_o, 1'b0, "ret_data_vld_o");
   endtask

   task bad_index(input logic [2:0] op, input aeg_idx_t idx);
      dispatch(make_inst(op, 5'd0, idx), rand_data());
      check_exc(exception_o, 16'h0002);
      check_bit(ret_data_vld_o, 1'b0, "ret_data_vld_o");
      next_cycle();
      check_exc(exception_o, 16'h0000);
   endtask

   task dispatch_and_check_exc(input inst_t inst, input logic [15:0] exp);
      dispatch(inst, rand_data());
      check_exc(exception_o, exp);
      check_bit(stall_at_disp, 1'b0, "stall_o in dispatch cycle");
      check_bit(stall_o, 1'b0, "stall_o");
      next_cycle();
      check_exc(exception_o, 16'h0000);
   endtask

   // **********************************************************************
   // Tests
   // **********************************************************************

   task apply_reset();
      reset_per = 1'b1;
      repeat (RESET_CYCLES) @(posedge clk);
      @(negedge clk);
      reset_per = 1'b0;
      #1;
   endtask

   task test_reset();
      int cycles;
      int idle_seen;
      cycles    = 0;
      idle_seen = 0;
      check_bit(stall_o, 1'b1, "stall_o");
      check_count(int'(aeg_cnt_o), `PERS_AEG_CNT, "aeg_cnt_o");
      while (stall_o && cycles < 4 * `PERS_MIN_BUSY) begin
         if (pe_cmd_o == idle_cmd) begin
            idle_seen++;
         end
         next_cycle();
         cycles++;
      end
      check_count(cycles, `PERS_MIN_BUSY, "stall cycles after reset");
      check_count(idle_seen, 1, "idle commands after reset");
      check_bit(idle_o, 1'b1, "idle_o");
      check_bit(ret_data_vld_o, 1'b0, "ret_data_vld_o");
      check_exc(exception_o, 16'h0000);
   endtask

   task test_aeg_rw();
      for (int i = 0; i < 2; i++) begin
         aeg_model[i] = rand_data();
         dispatch(make_inst(OP_AEG_WR, 5'd0, aeg_idx_t'(i)), aeg_model[i]);
         check_exc(exception_o, 16'h0000);
         check_bit(ret_data_vld_o, 1'b0, "ret_data_vld_o");
      end
      read_and_check(0);
      read_and_check(1);
   endtask

   task test_aeg_range();
      bad_index(OP_AEG_WR, 18'd2);
      bad_index(OP_AEG_RD, 18'd2);
      bad_index(OP_AEG_WR, 18'h3ffff);
      bad_index(OP_AEG_RD, 18'd7);
      read_and_check(0);
      read_and_check(1);
   endtask

   task test_unimpl();
      dispatch_and_check_exc(make_inst(3'd0, 5'd0, 18'd0), 16'h0001);
      dispatch_and_check_exc(make_inst(3'd7, 5'd0, 18'd0), 16'h0001);
      // Launch number under a bad opcode must not launch
      dispatch_and_check_exc(make_inst(3'd3, 5'd1, 18'd0), 16'h0001);
      dispatch_and_check_exc(make_inst(OP_CAEP, 5'd7, 18'd0), 16'h0001);
      dispatch_and_check_exc(make_inst(OP_CAEP, CAEP_NOP, 18'd0), 16'h0000);
      dispatch_and_check_exc(make_inst(OP_CAEP, CAEP_NOP2, 18'd0), 16'h0000);
   endtask

   task test_launch();
      int    k;
      data_t exp_cmd;
      aeg_model[0] = rand_data();
      dispatch(make_inst(OP_AEG_WR, 5'd0, 18'd0), aeg_model[0]);
      dispatch(make_inst(OP_CAEP, CAEP_LAUNCH, 18'd0), '0);
      check_bit(stall_at_disp, 1'b1, "stall_o in dispatch cycle");
      // k counts cycles from the dispatch
      k = 1;
      while (stall_o && k < 4 * `PERS_MIN_BUSY) begin
         exp_cmd = (k == 2) ? aeg_model[0] : '0;
         check_data(pe_cmd_o, exp_cmd, "pe_cmd_o");
         check_bit(idle_o, 1'b0, "idle_o");
         next_cycle();
         k++;
      end
      check_count(k, `PERS_MIN_BUSY + 2, "stall cycles after launch");
      check_data(pe_cmd_o, '0, "pe_cmd_o");
      check_bit(idle_o, 1'b1, "idle_o");
   endtask

   task test_watchdog();
      int    k;
      data_t exp_cmd;
      // Chain busy from the cycle before the dispatch
      // k counts cycles from the first busy one
      @(negedge clk);
      pe_busy_i = 1'b1;
      dispatch(make_inst(OP_CAEP, CAEP_LAUNCH, 18'd0), '0);
      check_bit(stall_at_disp, 1'b1, "stall_o in dispatch cycle");
      k = 2;
      while (k < BUSY_HOLD) begin
         if (k == 3) begin
            exp_cmd = aeg_model[0];
         end else if (k == `PERS_WDOG_LIMIT) begin
            exp_cmd = idle_cmd;
         end else begin
            exp_cmd = '0;
         end
         check_data(pe_cmd_o, exp_cmd, "pe_cmd_o");
         check_bit(stall_o, 1'b1, "stall_o");
         @(negedge clk);
         k++;
         if (k == BUSY_HOLD) begin
            pe_busy_i = 1'b0;
         end
         #1;
      end
      check_bit(stall_o, 1'b0, "stall_o");
      check_bit(idle_o, 1'b1, "idle_o");
      check_data(pe_cmd_o, '0, "pe_cmd_o");
   endtask

   initial begin
      errors        = 0;
      checks        = 0;
      seed          = 32'h9e59_031f;
      stall_at_disp = 1'b0;
      idle_cmd      = expected_idle_cmd();
      reset_per     = 1'b1;
      inst_i        = '0;
      data_i        = '0;
      inst_vld_i    = 1'b0;
      pe_busy_i     = 1'b0;

      apply_reset();
      test_reset();
      test_aeg_rw();
      test_aeg_range();
      test_unimpl();
      test_launch();
      test_watchdog();

      $display("Checks run: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// File: flist.f
+incdir+include
rtl/pers_pkg.sv
rtl/dispatch_if.sv
rtl/inst_decode.sv
rtl/aeg_regs.sv
rtl/launch_ctl.sv
rtl/pers_top.sv
bench/pers_tb.sv

// File: run.sh
#!/bin/sh
# Build with Verilator, run, then judge the run from the log

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module pers_tb -f flist.f \
   > build.log 2>&1 \
   || { cat build.log; echo "Build failed"; exit 1; }

./obj_dir/Vpers_tb > sim.log 2>&1 \
   || { cat sim.log; echo "Simulation exited with an error"; exit 1; }

cat sim.log

grep -q "Testbench failed" sim.log && { echo "FAIL"; exit 1; }
grep -q "Testbench passed" sim.log || { echo "FAIL: no result line"; exit 1; }
echo "PASS"
